// ==== include/pin_io_cfg.svh ====
`ifndef PIN_IO_CFG_SVH
`define PIN_IO_CFG_SVH

// Write data, time, rate and increment width.
`define PIN_DATA_W 32

// Command bus read data width.
`define PIN_RD_W 16

// Address width. High byte is the channel, low byte the register.
`define PIN_ADDR_W 16

// Number of pin channels in the bank.
`define PIN_CHANNELS 2

// Marker placed in the filler field of every sample word.
`define PIN_SAMPLE_TAG 12'hABC

`endif

// ==== verilog/pin_io_pkg.sv ====
package pin_io_pkg;

  // Command opcodes written to the command register.
  typedef enum logic [2:0] {
    CMD_NONE   = 3'd0,
    CMD_SQUARE = 3'd1,
    CMD_CONST  = 3'd2,
    CMD_STREAM = 3'd3,
    CMD_RESET  = 3'd5
  } pin_cmd_e;

  // Byte register addresses within a channel.
  typedef enum logic [7:0] {
    REG_INCREMENT    = 8'd1,
    REG_END_TIME     = 8'd2,
    REG_COMMAND      = 8'd3,
    REG_SAMPLE_RATE  = 8'd4,
    REG_SAMPLE_BIT   = 8'd5,
    REG_SAMPLE_COUNT = 8'd7,
    REG_STATUS       = 8'd8,
    REG_LAST_DATA    = 8'd9
  } pin_reg_e;

  // Channel sequencer states.
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SQUARE = 2'd1,
    ST_CONST  = 2'd2,
    ST_STREAM = 2'd3
  } pin_state_e;

  // Sample word returned on the sample port.
  // Top bit is always zero.
  typedef struct packed {
    logic        spare;
    logic [14:0] count;
    logic [11:0] tag;
    logic [2:0]  ones;
    logic        sample;
  } pin_sample_t;

endpackage

// ==== verilog/pin_ctrl_if.sv ====
`timescale 1ns/1ns

// Control strobes from the sequencer to the channel datapath.
interface pin_ctrl_if;

  logic output_en;
  logic const_one;
  logic rate_reload;
  logic rate_dec;
  logic sample_take;
  logic cmd_clear;

  modport ctrl (
    output output_en,
    output const_one,
    output rate_reload,
    output rate_dec,
    output sample_take,
    output cmd_clear
  );

  // Datapath side, the command clear goes to the register file.
  modport dp (
    input output_en,
    input const_one,
    input rate_reload,
    input rate_dec,
    input sample_take
  );

endinterface

// ==== verilog/pin_regs.sv ====
`timescale 1ns/1ns

`include "pin_io_cfg.svh"

module pin_regs #(
  parameter int POSITION = 0
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     enable,
  input  logic [`PIN_ADDR_W-1:0]   addr,
  input  logic                     data_wr,
  input  logic                     data_rd,
  input  logic [`PIN_DATA_W-1:0]   data_in,
  output logic [`PIN_RD_W-1:0]     data_out,
  output pin_io_pkg::pin_cmd_e     command,
  output logic [`PIN_DATA_W-1:0]   increment,
  output logic [`PIN_DATA_W-1:0]   end_time,
  output logic [`PIN_DATA_W-1:0]   sample_rate,
  input  logic                     sample_bit,
  input  logic [14:0]              sample_count,
  input  logic                     cmd_clear
);
  import pin_io_pkg::*;

  localparam logic [7:0] CHAN_BYTE = POSITION[7:0];
  localparam logic [`PIN_RD_W-1:0] STATUS_WORD = POSITION[`PIN_RD_W-1:0];

  logic                   chan_sel;
  logic [7:0]             reg_addr;
  logic [`PIN_DATA_W-1:0] last_data;

  // Only the four defined opcodes are kept.
  function automatic pin_cmd_e decode_cmd(input logic [`PIN_DATA_W-1:0] value);
    pin_cmd_e cmd;
    cmd = CMD_NONE;
    if (value[`PIN_DATA_W-1:3] == '0) begin
      case (value[2:0])
        3'd1:    cmd = CMD_SQUARE;
        3'd2:    cmd = CMD_CONST;
        3'd3:    cmd = CMD_STREAM;
        3'd5:    cmd = CMD_RESET;
        default: cmd = CMD_NONE;
      endcase
    end
    return cmd;
  endfunction

  assign chan_sel = enable && (addr[`PIN_ADDR_W-1:8] == CHAN_BYTE);
  assign reg_addr = addr[7:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      increment   <= '0;
      end_time    <= '0;
      sample_rate <= '0;
      last_data   <= '0;
    end else if (chan_sel && data_wr) begin
      last_data <= data_in;
      case (reg_addr)
        REG_INCREMENT:   increment   <= data_in;
        REG_END_TIME:    end_time    <= data_in;
        REG_SAMPLE_RATE: sample_rate <= data_in;
        default: ;
      endcase
    end
  end

  // The sequencer consumes a command by clearing it.
  always_ff @(posedge clk) begin
    if (reset || cmd_clear) begin
      command <= CMD_NONE;
    end else if (chan_sel && data_wr && reg_addr == REG_COMMAND) begin
      command <= decode_cmd(data_in);
    end
  end

  // Registered read-back, zero when not read.
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (chan_sel && data_rd) begin
      case (reg_addr)
        REG_SAMPLE_BIT:   data_out <= {{(`PIN_RD_W-1){1'b0}}, sample_bit};
        REG_SAMPLE_COUNT: data_out <= {{(`PIN_RD_W-15){1'b0}}, sample_count};
        REG_STATUS:       data_out <= STATUS_WORD;
        REG_LAST_DATA:    data_out <= last_data[`PIN_RD_W-1:0];
        default:          data_out <= '0;
      endcase
    end else begin
      data_out <= '0;
    end
  end

endmodule

// ==== verilog/pin_sequencer.sv ====
`timescale 1ns/1ns

`include "pin_io_cfg.svh"

module pin_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  pin_io_pkg::pin_cmd_e   command,
  input  logic [`PIN_DATA_W-1:0] current_time,
  input  logic [`PIN_DATA_W-1:0] end_time,
  input  logic                   rate_expired,
  pin_ctrl_if.ctrl               ctrl
);
  import pin_io_pkg::*;

  pin_state_e state;
  pin_state_e state_next;
  logic       clear_next;
  logic       time_up;

  assign time_up = (current_time >= end_time);

  always_comb begin
    state_next = state;
    clear_next = 1'b0;
    case (state)
      ST_IDLE: begin
        // A reset command in idle is simply consumed.
        case (command)
          CMD_SQUARE: begin
            state_next = ST_SQUARE;
            clear_next = 1'b1;
          end
          CMD_CONST: begin
            state_next = ST_CONST;
            clear_next = 1'b1;
          end
          CMD_STREAM: begin
            state_next = ST_STREAM;
            clear_next = 1'b1;
          end
          CMD_RESET: begin
            clear_next = 1'b1;
          end
          default: ;
        endcase
      end
      ST_SQUARE, ST_CONST: begin
        if (command == CMD_RESET) begin
          state_next = ST_IDLE;
          clear_next = 1'b1;
        end else if (time_up) begin
          state_next = ST_IDLE;
        end
      end
      ST_STREAM: begin
        // Streaming only stops on a reset command.
        if (command == CMD_RESET) begin
          state_next = ST_IDLE;
          clear_next = 1'b1;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= ST_IDLE;
      ctrl.cmd_clear <= 1'b0;
      ctrl.output_en <= 1'b0;
      ctrl.const_one <= 1'b0;
    end else begin
      state          <= state_next;
      ctrl.cmd_clear <= clear_next;
      ctrl.output_en <= (state == ST_SQUARE) || (state == ST_CONST);
      ctrl.const_one <= (state == ST_CONST);
    end
  end

  // Rate counter strobes.
  assign ctrl.rate_reload = (state == ST_IDLE) || (state == ST_STREAM && rate_expired);
  assign ctrl.rate_dec    = (state == ST_STREAM) && !rate_expired;
  assign ctrl.sample_take = (state == ST_STREAM) && rate_expired;

endmodule

// ==== verilog/pin_nco.sv ====
`timescale 1ns/1ns

`include "pin_io_cfg.svh"

module pin_nco (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`PIN_DATA_W-1:0] increment,
  pin_ctrl_if.dp                 ctrl,
  output logic                   phase_msb
);

  logic [`PIN_DATA_W-1:0] phase;

  // Output frequency is about f_clk * increment / 2^32.
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (ctrl.const_one) begin
      phase <= '1;
    end else begin
      phase <= phase + increment;
    end
  end

  assign phase_msb = phase[`PIN_DATA_W-1];

endmodule

// ==== verilog/pin_sampler.sv ====
`timescale 1ns/1ns

`include "pin_io_cfg.svh"

module pin_sampler (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`PIN_DATA_W-1:0] sample_rate,
  input  logic                   pin_in,
  pin_ctrl_if.dp                 ctrl,
  output logic                   rate_expired,
  output logic                   sample_bit,
  output logic [14:0]            sample_count
);

  localparam logic [`PIN_DATA_W-1:0] RATE_ONE = 1;

  logic [`PIN_DATA_W-1:0] rate_cnt;
  logic [1:0]             pin_sync;

  // Two-flop synchronizer on the asynchronous pin.
  always_ff @(posedge clk) begin
    if (reset) begin
      pin_sync <= '0;
    end else begin
      pin_sync <= {pin_sync[0], pin_in};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rate_cnt <= '0;
    end else if (ctrl.rate_reload) begin
      rate_cnt <= sample_rate;
    end else if (ctrl.rate_dec) begin
      rate_cnt <= rate_cnt - RATE_ONE;
    end
  end

  assign rate_expired = (rate_cnt <= RATE_ONE);

  // Count wraps at 15 bits.
  always_ff @(posedge clk) begin
    if (reset) begin
      sample_bit   <= 1'b0;
      sample_count <= '0;
    end else if (ctrl.sample_take) begin
      sample_bit   <= pin_sync[1];
      sample_count <= sample_count + 15'd1;
    end
  end

endmodule

// ==== verilog/pin_channel.sv ====
`timescale 1ns/1ns

`include "pin_io_cfg.svh"

module pin_channel #(
  parameter int POSITION = 0
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  logic [`PIN_ADDR_W-1:0]  addr,
  input  logic                    data_wr,
  input  logic                    data_rd,
  input  logic [`PIN_DATA_W-1:0]  data_in,
  output logic [`PIN_RD_W-1:0]    data_out,
  input  logic [`PIN_DATA_W-1:0]  current_time,
  output pin_io_pkg::pin_sample_t sample_word,
  output logic                    pin_out,
  output logic                    pin_oe,
  input  logic                    pin_in
);
  import pin_io_pkg::*;

  pin_cmd_e               command;
  logic [`PIN_DATA_W-1:0] increment;
  logic [`PIN_DATA_W-1:0] end_time;
  logic [`PIN_DATA_W-1:0] sample_rate;
  logic                   rate_expired;
  logic                   sample_bit;
  logic [14:0]            sample_count;
  logic                   phase_msb;

  pin_ctrl_if ctrl_if ();

  pin_regs #(.POSITION(POSITION)) i_pin_regs (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .addr         (addr),
    .data_wr      (data_wr),
    .data_rd      (data_rd),
    .data_in      (data_in),
    .data_out     (data_out),
    .command      (command),
    .increment    (increment),
    .end_time     (end_time),
    .sample_rate  (sample_rate),
    .sample_bit   (sample_bit),
    .sample_count (sample_count),
    .cmd_clear    (ctrl_if.cmd_clear)
  );

  pin_sequencer i_pin_sequencer (
    .clk          (clk),
    .reset        (reset),
    .command      (command),
    .current_time (current_time),
    .end_time     (end_time),
    .rate_expired (rate_expired),
    .ctrl         (ctrl_if.ctrl)
  );

  pin_nco i_pin_nco (
    .clk       (clk),
    .reset     (reset),
    .increment (increment),
    .ctrl      (ctrl_if.dp),
    .phase_msb (phase_msb)
  );

  pin_sampler i_pin_sampler (
    .clk          (clk),
    .reset        (reset),
    .sample_rate  (sample_rate),
    .pin_in       (pin_in),
    .ctrl         (ctrl_if.dp),
    .rate_expired (rate_expired),
    .sample_bit   (sample_bit),
    .sample_count (sample_count)
  );

  assign pin_out = phase_msb;
  assign pin_oe  = ctrl_if.output_en;

  assign sample_word = '{
    spare:  1'b0,
    count:  sample_count,
    tag:    `PIN_SAMPLE_TAG,
    ones:   3'b111,
    sample: sample_bit
  };

endmodule

// ==== verilog/pin_io_bank.sv ====
`timescale 1ns/1ns

`include "pin_io_cfg.svh"

module pin_io_bank (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     enable,
  input  logic [`PIN_ADDR_W-1:0]   addr,
  input  logic                     data_wr,
  input  logic                     data_rd,
  input  logic [`PIN_DATA_W-1:0]   data_in,
  output logic [`PIN_RD_W-1:0]     data_out,
  input  logic [`PIN_DATA_W-1:0]   current_time,
  input  logic                     output_sample,
  input  logic [7:0]               channel_select,
  output logic [`PIN_DATA_W-1:0]   sample_data,
  output logic [`PIN_CHANNELS-1:0] pin_out,
  output logic [`PIN_CHANNELS-1:0] pin_oe,
  input  logic [`PIN_CHANNELS-1:0] pin_in
);
  import pin_io_pkg::*;

  logic [`PIN_RD_W-1:0] chan_rd   [`PIN_CHANNELS];
  pin_sample_t          chan_word [`PIN_CHANNELS];
  pin_sample_t          word_sel;

  for (genvar i = 0; i < `PIN_CHANNELS; i++) begin : g_chan
    pin_channel #(.POSITION(i)) i_pin_channel (
      .clk          (clk),
      .reset        (reset),
      .enable       (enable),
      .addr         (addr),
      .data_wr      (data_wr),
      .data_rd      (data_rd),
      .data_in      (data_in),
      .data_out     (chan_rd[i]),
      .current_time (current_time),
      .sample_word  (chan_word[i]),
      .pin_out      (pin_out[i]),
      .pin_oe       (pin_oe[i]),
      .pin_in       (pin_in[i])
    );
  end

  // Unselected channels return zero, so an OR combines them.
  always_comb begin
    data_out = '0;
    for (int i = 0; i < `PIN_CHANNELS; i++) begin
      data_out = data_out | chan_rd[i];
    end
  end

  // Out-of-range channel numbers select nothing.
  always_comb begin
    word_sel = '0;
    for (int i = 0; i < `PIN_CHANNELS; i++) begin
      if (channel_select == 8'(i)) begin
        word_sel = chan_word[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !output_sample) begin
      sample_data <= '0;
    end else begin
      sample_data <= word_sel;
    end
  end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ns

// Free-running clock, 4 ns period by default.
module tb_clock_gen #(
  parameter int HALF_PERIOD = 2
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #HALF_PERIOD clk = ~clk;
  end

endmodule

// ==== dv/pin_io_bank_tb.sv ====
`timescale 1ns/1ns

`include "pin_io_cfg.svh"

module pin_io_bank_tb;
  import pin_io_pkg::*;

  localparam int OP_WRITE    = 0;
  localparam int OP_READ     = 1;
  localparam int OP_HOLD     = 2;
  localparam int OP_WAIT_OE  = 3;
  localparam int OP_WAIT_OUT = 4;
  localparam int OP_PERIOD   = 5;
  localparam int OP_POLL     = 6;
  localparam int OP_RATE     = 7;
  localparam int OP_SAMPLE   = 8;
  localparam int OP_REPORT   = 9;

  // One table row. For wait rows data is the timeout, for hold rows the length.
  typedef struct {
    int          op;
    int          ch;
    logic [7:0]  rg;
    logic [31:0] data;
    logic [31:0] tval;
    logic [1:0]  pins;
    logic [31:0] expv;
  } row_t;

  logic                     clk;
  logic                     reset;
  logic                     enable;
  logic [`PIN_ADDR_W-1:0]   addr;
  logic                     data_wr;
  logic                     data_rd;
  logic [`PIN_DATA_W-1:0]   data_in;
  logic [`PIN_RD_W-1:0]     data_out;
  logic [`PIN_DATA_W-1:0]   current_time;
  logic                     output_sample;
  logic [7:0]               channel_select;
  logic [`PIN_DATA_W-1:0]   sample_data;
  logic [`PIN_CHANNELS-1:0] pin_out;
  logic [`PIN_CHANNELS-1:0] pin_oe;
  logic [`PIN_CHANNELS-1:0] pin_in;

  int          errors;
  int          checks;
  int          test_base;
  logic [31:0] rng_state;
  logic [31:0] build_time;
  logic [1:0]  build_pins;
  row_t        rows[$];
  string       names[$];
  // Reference model of each channel's sample state.
  logic [14:0] model_count [`PIN_CHANNELS];
  logic        model_bit   [`PIN_CHANNELS];

  tb_clock_gen i_tb_clock_gen (.clk(clk));

  pin_io_bank i_pin_io_bank (
    .clk            (clk),
    .reset          (reset),
    .enable         (enable),
    .addr           (addr),
    .data_wr        (data_wr),
    .data_rd        (data_rd),
    .data_in        (data_in),
    .data_out       (data_out),
    .current_time   (current_time),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .sample_data    (sample_data),
    .pin_out        (pin_out),
    .pin_oe         (pin_oe),
    .pin_in         (pin_in)
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] expv);
    checks++;
    if (got !== expv) begin
      $display("ERROR time %0t %s got %h expected %h", $time, name, got, expv);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    checks++;
    errors++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  task automatic add_row(input int op, input int ch, input logic [7:0] rg,
                         input logic [31:0] data, input logic [31:0] expv);
    row_t r;
    r.op   = op;
    r.ch   = ch;
    r.rg   = rg;
    r.data = data;
    r.tval = build_time;
    r.pins = build_pins;
    r.expv = expv;
    rows.push_back(r);
  endtask

  // Closes a test and puts a random idle gap after it.
  task automatic end_test(input string name);
    logic [31:0] rnd;
    rnd = next_random();
    add_row(OP_REPORT, names.size(), 8'd0, 32'd0, 32'd0);
    names.push_back(name);
    add_row(OP_HOLD, 0, 8'd0, 32'(rnd[1:0]), 32'd0);
  endtask

  task automatic build_table();
    logic [31:0] w [2];
    logic [31:0] rnd;
    build_time = 32'd0;
    build_pins = 2'b00;
    for (int ch = 0; ch < 2; ch++) begin
      w[ch] = next_random();
      add_row(OP_WRITE, ch, REG_INCREMENT, w[ch], 32'd0);
    end
    for (int ch = 0; ch < 2; ch++) begin
      add_row(OP_READ, ch, REG_LAST_DATA, 32'd0, 32'(w[ch][15:0]));
      add_row(OP_READ, ch, REG_STATUS, 32'd0, 32'(ch));
    end
    // Channel byte 2 has no channel behind it.
    add_row(OP_READ, 2, REG_STATUS, 32'd0, 32'd0);
    end_test("register read-back");

    add_row(OP_WRITE, 0, REG_END_TIME, 32'd100, 32'd0);
    add_row(OP_WRITE, 0, REG_INCREMENT, 32'h8000_0000, 32'd0);
    add_row(OP_WRITE, 0, REG_COMMAND, 32'(CMD_CONST), 32'd0);
    add_row(OP_WAIT_OE, 0, 8'd0, 32'd3, 32'd1);
    add_row(OP_WAIT_OUT, 0, 8'd0, 32'd3, 32'd1);
    // A toggling accumulator would drop the pin on the next cycle.
    add_row(OP_WAIT_OUT, 0, 8'd0, 32'd1, 32'd1);
    build_time = 32'd100;
    add_row(OP_WAIT_OE, 0, 8'd0, 32'd3, 32'd0);
    end_test("constant mode");

    add_row(OP_WRITE, 1, REG_END_TIME, 32'd1000, 32'd0);
    add_row(OP_WRITE, 1, REG_INCREMENT, 32'h8000_0000, 32'd0);
    add_row(OP_WRITE, 1, REG_COMMAND, 32'(CMD_SQUARE), 32'd0);
    add_row(OP_WAIT_OE, 1, 8'd0, 32'd3, 32'd1);
    add_row(OP_PERIOD, 1, 8'd0, 32'd0, 32'd1);
    add_row(OP_WRITE, 1, REG_INCREMENT, 32'h4000_0000, 32'd0);
    add_row(OP_PERIOD, 1, 8'd0, 32'd0, 32'd2);
    add_row(OP_WRITE, 1, REG_COMMAND, 32'(CMD_RESET), 32'd0);
    add_row(OP_WAIT_OE, 1, 8'd0, 32'd3, 32'd0);
    end_test("square wave");

    rnd = next_random();
    build_pins = rnd[1:0];
    model_bit[0] = rnd[0];
    model_bit[1] = 1'b0;
    model_count[1] = 15'd0;
    add_row(OP_WRITE, 0, REG_SAMPLE_RATE, 32'd5, 32'd0);
    add_row(OP_WRITE, 0, REG_COMMAND, 32'(CMD_STREAM), 32'd0);
    add_row(OP_POLL, 0, 8'd0, 32'd20, 32'd4);
    // 50 cycles at rate 5 gives about ten samples.
    add_row(OP_RATE, 0, 8'd0, 32'd49, 32'd10);
    add_row(OP_READ, 0, REG_SAMPLE_BIT, 32'd0, 32'(rnd[0]));
    add_row(OP_WRITE, 0, REG_COMMAND, 32'(CMD_RESET), 32'd0);
    add_row(OP_POLL, 0, 8'd0, 32'd2, 32'd0);
    add_row(OP_READ, 1, REG_SAMPLE_COUNT, 32'd0, 32'd0);
    end_test("input stream");

    add_row(OP_SAMPLE, 0, 8'd0, 32'd0, 32'd0);
    add_row(OP_SAMPLE, 1, 8'd0, 32'd0, 32'd0);
    add_row(OP_SAMPLE, 5, 8'd0, 32'd0, 32'd0);
    end_test("sample port");
  endtask

  // Bus tasks start right after a rising edge.
  task automatic bus_write(input int ch, input logic [7:0] rg, input logic [31:0] value);
    enable  <= 1'b1;
    addr    <= {8'(ch), rg};
    data_in <= value;
    data_wr <= 1'b1;
    @(posedge clk);
    enable  <= 1'b0;
    data_wr <= 1'b0;
  endtask

  task automatic bus_read(input int ch, input logic [7:0] rg, output logic [15:0] value);
    enable  <= 1'b1;
    addr    <= {8'(ch), rg};
    data_rd <= 1'b1;
    @(posedge clk);
    enable  <= 1'b0;
    data_rd <= 1'b0;
    @(negedge clk);
    value = data_out;
  endtask

  task automatic wait_level(input int ch, input bit use_oe, input logic [31:0] timeout,
                            input logic expv);
    logic got;
    got = ~expv;
    for (int n = 0; n < int'(timeout); n++) begin
      @(negedge clk);
      got = use_oe ? pin_oe[ch] : pin_out[ch];
      if (got === expv) break;
    end
    if (got !== expv) begin
      report_failure($sformatf("channel %0d %s did not reach %0b in %0d cycles",
                               ch, use_oe ? "pin_oe" : "pin_out", expv, timeout));
    end
  endtask

  // Cycles between two pin_out edges, or -1 on a timeout.
  task automatic measure_half_period(input int ch, output int cycles);
    logic last;
    cycles = -1;
    @(negedge clk);
    last = pin_out[ch];
    for (int n = 0; n < 16; n++) begin
      @(negedge clk);
      if (pin_out[ch] !== last) break;
    end
    last = pin_out[ch];
    for (int n = 1; n <= 16; n++) begin
      @(negedge clk);
      if (pin_out[ch] !== last) begin
        cycles = n;
        break;
      end
    end
    if (cycles < 0) begin
      report_failure($sformatf("channel %0d pin_out stopped toggling", ch));
    end
  endtask

  task automatic poll_count(input row_t r);
    logic [15:0] v;
    bit          done;
    done = 1'b0;
    for (int n = 0; n < int'(r.data) && !done; n++) begin
      bus_read(r.ch, REG_SAMPLE_COUNT, v);
      done = (32'(v) >= r.expv);
      if (!done) @(posedge clk);
    end
    if (done) begin
      model_count[r.ch] = v[14:0];
    end else begin
      report_failure($sformatf("channel %0d sample count never reached %0d", r.ch, r.expv));
    end
  endtask

  task automatic check_rate(input row_t r);
    logic [15:0] c1;
    logic [15:0] c2;
    int          d;
    bus_read(r.ch, REG_SAMPLE_COUNT, c1);
    repeat (r.data) @(posedge clk);
    bus_read(r.ch, REG_SAMPLE_COUNT, c2);
    d = int'(c2) - int'(c1);
    checks++;
    if (d < int'(r.expv) - 1 || d > int'(r.expv) + 1) begin
      report_failure($sformatf("sample count rose by %0d, expected about %0d", d, r.expv));
    end
  endtask

  task automatic check_sample_port(input int ch);
    logic [31:0] expv;
    expv = 32'd0;
    if (ch < `PIN_CHANNELS) begin
      expv = {1'b0, model_count[ch], `PIN_SAMPLE_TAG, 3'b111, model_bit[ch]};
    end
    output_sample  <= 1'b1;
    channel_select <= 8'(ch);
    @(posedge clk);
    output_sample <= 1'b0;
    @(negedge clk);
    compare($sformatf("sample_data[ch %0d]", ch), sample_data, expv);
  endtask

  task automatic check_idle_outputs();
    compare("pin_oe", 32'(pin_oe), 32'd0);
    compare("data_out", 32'(data_out), 32'd0);
    compare("sample_data", sample_data, 32'd0);
  endtask

  initial begin
    row_t        r;
    logic [15:0] v;
    int          cycles;
    errors         = 0;
    checks         = 0;
    rng_state      = 32'd41;
    reset          = 1'b1;
    enable         = 1'b0;
    addr           = '0;
    data_wr        = 1'b0;
    data_rd        = 1'b0;
    data_in        = '0;
    current_time   = '0;
    output_sample  = 1'b0;
    channel_select = '0;
    pin_in         = '0;
    build_table();

    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    reset <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_idle_outputs();
    end
    $display("test reset state: %0d errors", errors);
    test_base = errors;

    foreach (rows[i]) begin
      r = rows[i];
      @(posedge clk);
      current_time <= r.tval;
      pin_in       <= r.pins;
      case (r.op)
        OP_WRITE:    bus_write(r.ch, r.rg, r.data);
        OP_READ: begin
          bus_read(r.ch, r.rg, v);
          compare($sformatf("data_out[ch %0d reg %0d]", r.ch, r.rg), 32'(v), r.expv);
        end
        OP_HOLD:     repeat (r.data) @(posedge clk);
        OP_WAIT_OE:  wait_level(r.ch, 1'b1, r.data, r.expv[0]);
        OP_WAIT_OUT: wait_level(r.ch, 1'b0, r.data, r.expv[0]);
        OP_PERIOD: begin
          measure_half_period(r.ch, cycles);
          compare("pin_out half period", cycles, r.expv);
        end
        OP_POLL:     poll_count(r);
        OP_RATE:     check_rate(r);
        OP_SAMPLE:   check_sample_port(r.ch);
        default: begin
          $display("test %s: %0d errors", names[r.ch], errors - test_base);
          test_base = errors;
        end
      endcase
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== pin_io_bank.f ====
+incdir+include
verilog/pin_io_pkg.sv
verilog/pin_ctrl_if.sv
verilog/pin_regs.sv
verilog/pin_sequencer.sv
verilog/pin_nco.sv
verilog/pin_sampler.sv
verilog/pin_channel.sv
verilog/pin_io_bank.sv
dv/tb_clock_gen.sv
dv/pin_io_bank_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pin_io_bank testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f pin_io_bank.f --top-module pin_io_bank_tb \
  -o pin_io_bank_sim
./obj_dir/pin_io_bank_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
